// File: sources.f
src/board_pkg.sv
src/slow_tick_gen.sv
src/seven_seg_encoder.sv
src/lab_top.sv
src/tm1638_board_controller.sv
src/board_specific_top.sv
verif/tm1638_checker.sv
verif/tb_board_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in the log

set -u

cd "$(dirname "$0")"

log_file=sim.log
build_dir=obj_dir

verilator --binary --timing -Wno-fatal \
    --top-module tb_board_top \
    -f sources.f \
    --Mdir "$build_dir" -o tb_board_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/tb_board_top" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "=== PASS ===" "$log_file"; then
    exit 0
else
    exit 1
fi

// File: verif/tb_board_top.sv
`default_nettype none

module tb_board_top;

    import board_pkg::*;

    localparam int w_key        = 3;
    localparam int w_sw         = 2;
    localparam int w_led        = 2;
    localparam int clk_period   = 4;
    localparam int reset_cycles = 10;
    localparam int drive_delay  = 1;
    localparam int stb_timeout  = 2000;  // Cycles without a strobe rise
    localparam int tick_cycles  = 50;
    localparam int n_rows       = 19;

    // One row per step, a hold of 0 lets the LCG pick the length of a tick run
    localparam logic [7:0]         row_keys [n_rows] = '{
        8'h01, 8'h01, 8'h00, 8'h02, 8'h03, 8'h00, 8'h03, 8'h00, 8'h81, 8'h00,
        8'h55, 8'hAA, 8'h00, 8'h00, 8'h80, 8'h00, 8'h00, 8'h80, 8'h01};
    localparam logic [w_sw - 1:0]  row_sw   [n_rows] = '{
        0, 0, 0, 0, 0, 0, 0, 2, 2, 2, 0, 0, 0, 1, 0, 0, 3, 2, 0};
    localparam int                 row_hold [n_rows] = '{
        2, 2, 2, 2, 2, 2, 2, 3, 2, 2, 2, 2, 2, 0, 2, 2, 0, 2, 2};
    localparam logic [w_count-1:0] row_exp  [n_rows] = '{
        32'h1, 32'h1, 32'h1, 32'h11, 32'h12, 32'h12, 32'h23, 32'h23, 32'h0, 32'h0,
        32'h1, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h1};

    logic                 clk       = 1'b0;
    logic [w_key - 1:0]   key;
    logic [w_sw  - 1:0]   sw;
    logic                 tm_dio_in = 1'b1;
    wire  [w_led - 1:0]   led;
    wire                  tm_sio_clk;
    wire                  tm_sio_stb;
    wire                  tm_dio_out;
    wire                  tm_dio_oe;
    wire                  reset     = ~ key[w_key - 1];
    logic [7:0]           pressed_keys;
    logic [w_count - 1:0] exp_count;
    logic                 exp_blank;
    logic                 exact;
    logic                 mono;
    logic                 timed_out;
    logic [31:0]          lcg_state;
    int                   mismatch_count;
    int                   other_count;

    always #(clk_period / 2) clk = ~ clk;

    board_specific_top
    #(
        .clk_mhz            ( 1     ),
        .slow_tick_hz       ( 20000 ),
        .tm_half_bit_cycles ( 2     ),
        .w_key              ( w_key ),
        .w_sw               ( w_sw  ),
        .w_led              ( w_led )
    )
    u_dut
    (
        .CLK        ( clk        ),
        .KEY        ( key        ),
        .SW         ( sw         ),
        .LED        ( led        ),
        .tm_sio_clk ( tm_sio_clk ),
        .tm_sio_stb ( tm_sio_stb ),
        .tm_dio_out ( tm_dio_out ),
        .tm_dio_oe  ( tm_dio_oe  ),
        .tm_dio_in  ( tm_dio_in  )
    );

    tm1638_checker #(.w_led (w_led), .tick_cycles (tick_cycles)) u_checker
    (
        .clk            ( clk            ),
        .reset          ( reset          ),
        .sio_clk        ( tm_sio_clk     ),
        .sio_stb        ( tm_sio_stb     ),
        .dio_out        ( tm_dio_out     ),
        .dio_oe         ( tm_dio_oe      ),
        .dio_in         ( tm_dio_in      ),
        .led            ( led            ),
        .exp_count      ( exp_count      ),
        .exp_blank      ( exp_blank      ),
        .exact          ( exact          ),
        .mono           ( mono           ),
        .mismatch_count ( mismatch_count ),
        .other_count    ( other_count    )
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Key k sits in bit 0 (even k) or bit 4 (odd k) of key byte k/2
    function automatic logic key_answer(input int idx);
        int pos;
        pos = idx % 8;
        if (pos == 0)
            return pressed_keys[(idx / 8) * 2];
        if (pos == 4)
            return pressed_keys[(idx / 8) * 2 + 1];
        return 1'b0;
    endfunction

    // Panel model that answers the key read command on the data line
    logic       model_sclk = 1'b1;
    logic       model_stb  = 1'b1;
    logic [7:0] model_cmd  = 8'h00;
    int         model_bits = 0;     // Clock rises since the strobe fell

    always @(posedge clk)
    begin
        #drive_delay;
        if (model_stb && !tm_sio_stb)
        begin
            model_bits = 0;
            model_cmd  = 8'h00;
        end
        if (!model_sclk && tm_sio_clk && !tm_sio_stb)
        begin
            if (model_bits < 8)
                model_cmd[model_bits] = tm_dio_out;
            model_bits++;
        end
        if (model_sclk && !tm_sio_clk)
        begin
            if (model_cmd == tm_cmd_read_keys && model_bits >= 8 && model_bits < 40)
                tm_dio_in = key_answer(model_bits - 8);
            else
                tm_dio_in = 1'b1;
        end
        if (tm_sio_stb)
            tm_dio_in = 1'b1;
        model_sclk = tm_sio_clk;
        model_stb  = tm_sio_stb;
    end

    // A frame ends with its fourth strobe rise
    task automatic wait_frames(input int frames);
        int   rises;
        int   idle;
        logic last;
        rises = 0;
        idle  = 0;
        last  = tm_sio_stb;
        while (rises < 4 * frames && !timed_out)
        begin
            @(posedge clk);
            #drive_delay;
            if (!last && tm_sio_stb)
            begin
                rises++;
                idle = 0;
            end
            else
                idle++;
            last = tm_sio_stb;
            if (idle > stb_timeout)
            begin
                $display("timeout: the panel strobe did not rise within %0d cycles", stb_timeout);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic apply_row(input int r);
        int hold;
        pressed_keys = row_keys[r];
        sw           = row_sw[r];
        exact        = 1'b0;            // The next frame may still show the old state
        mono         = row_sw[r][0];
        hold         = row_hold[r];
        if (hold == 0)
            hold = 2 + int'(next_rand() >> 16) % 3;
        wait_frames(1);
        if (!timed_out)
        begin
            exact     = !row_sw[r][0];
            exp_count = row_exp[r];
            exp_blank = row_sw[r][1];
            wait_frames(hold - 1);
        end
    endtask

    initial
    begin
        key              = '1;
        key[w_key - 1]   = 1'b0;
        sw               = '0;
        pressed_keys     = 8'h00;
        exp_count        = '0;
        exp_blank        = 1'b0;
        exact            = 1'b1;        // The first frame shows zero in every digit
        mono             = 1'b0;
        timed_out        = 1'b0;
        lcg_state        = 32'h4ecb;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        key[w_key - 1] = 1'b1;
        wait_frames(1);
        for (int r = 0; r < n_rows && !timed_out; r++)
            apply_row(r);
        $display("closing: %0d mismatches, %0d other errors, timeout %0d",
                 mismatch_count, other_count, timed_out);
        if (!timed_out && mismatch_count == 0 && other_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tm1638_checker.sv
`default_nettype none

module tm1638_checker
#(
    parameter w_led       = 2,
              tick_cycles = 50
)
(
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             sio_clk,
    input  wire                             sio_stb,
    input  wire                             dio_out,
    input  wire                             dio_oe,
    input  wire                             dio_in,
    input  wire  [w_led - 1:0]              led,
    input  wire  [board_pkg::w_count - 1:0] exp_count,
    input  wire                             exp_blank,
    input  wire                             exact,    // Digits must show exp_count
    input  wire                             mono,     // Digits may only climb
    output int                              mismatch_count,
    output int                              other_count
);

    import board_pkg::*;

    // Commands of one frame in order, with their length in bytes
    localparam logic [7:0] cmd_order [4] = '{tm_cmd_write_auto, tm_cmd_addr0,
                                             tm_cmd_display_on, tm_cmd_read_keys};
    localparam int         len_order [4] = '{1, 17, 1, 5};

    logic [7:0]            cmd_bytes [17];
    logic [7:0]            shift         = 8'h00;
    int                    n_bytes       = 0;
    int                    n_bits        = 0;
    int                    step          = 0;
    logic                  prev_sclk     = 1'b1;
    logic                  prev_stb      = 1'b1;
    logic                  frame_started = 1'b0;
    logic [w_tm_key - 1:0] prev_keys     = '0;  // Keys read in the previous frame
    logic [w_count - 1:0]  prev_value    = '0;
    logic                  prev_valid    = 1'b0;
    int                    cycle         = 0;
    int                    panel_cycle   = 0;
    int                    n_mismatch    = 0;
    int                    n_other       = 0;

    assign mismatch_count = n_mismatch;
    assign other_count    = n_other;

    function automatic logic [7:0] flip(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++)
            r[i] = b[7 - i];
        return r;
    endfunction

    // Panel byte for digit d with segment a in bit 0
    function automatic logic [7:0] expected_digit(input int d);
        int top;
        top = 0;                                       // Highest nonzero digit
        for (int i = 1; i < w_tm_digit; i++)
            if (exp_count[i * 4 +: 4] != 4'd0)
                top = i;
        if (exp_blank && d > top)
            return 8'h00;
        return flip(seg_font[exp_count[d * 4 +: 4]]);
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        $display("mismatch %s: got %h, expected %h at cycle %0d", name, got, want, cycle);
        n_mismatch++;
    endtask

    task automatic report_other(input string what);
        $display("error: %s at cycle %0d", what, cycle);
        n_other++;
    endtask

    task automatic check_panel();
        logic [w_count - 1:0] value;
        logic [7:0]           seg;
        logic [w_led - 1:0]   want_led;
        int                   nib;
        int                   limit;
        int                   least;
        value = '0;
        for (int d = 0; d < w_tm_digit; d++)
        begin
            seg = cmd_bytes[1 + 2 * d];
            if (exact && seg != expected_digit(d))
                report_value($sformatf("digit %0d", d), seg, expected_digit(d));
            if (cmd_bytes[2 + 2 * d] != {7'd0, prev_keys[d]})
                report_value($sformatf("panel led %0d", d), cmd_bytes[2 + 2 * d], prev_keys[d]);
            nib = (seg == 8'h00) ? 0 : -1;             // A blank digit reads as zero
            for (int v = 0; v < 16; v++)
                if (flip(seg_font[v]) == seg)
                    nib = v;
            if (mono && nib < 0)
                report_other($sformatf("digit %0d shows the unknown pattern %h", d, seg));
            else if (nib > 0)
                value[d * 4 +: 4] = 4'(nib);
        end
        want_led = ~ exp_count[w_led - 1:0];
        if (exact && led != want_led)
            report_value("LED", led, want_led);
        if (mono)
        begin
            limit = (cycle - panel_cycle) / tick_cycles + 1;
            least = limit - 2;                         // Fewest ticks a frame can hold
            if (prev_valid && value < prev_value)
                report_value("count fell", value, prev_value);
            else if (prev_valid && value - prev_value > limit)
                report_value("count step", value - prev_value, limit);
            else if (prev_valid && least > 0 && value - prev_value < least)
                report_value("count step", value - prev_value, least);
            prev_value = value;
        end
        prev_valid  = mono;
        panel_cycle = cycle;
    endtask

    task automatic end_command();
        if (n_bits != 0 || n_bytes != len_order[step])
            report_other($sformatf("command %0d carried %0d bytes and %0d stray bits, not %0d bytes",
                                   step, n_bytes, n_bits, len_order[step]));
        else if (cmd_bytes[0] != cmd_order[step])
            report_value("command byte", cmd_bytes[0], cmd_order[step]);
        else if (step == 1)
            check_panel();
        else if (step == 3)
            for (int k = 0; k < w_tm_key; k++)
                prev_keys[k] = cmd_bytes[1 + k / 2][(k % 2) * 4];
        step = (step + 1) % 4;
    endtask

    task automatic take_bit();
        logic reading;
        logic b;
        reading = (n_bytes > 0) && (cmd_bytes[0] == tm_cmd_read_keys);
        if (dio_oe == reading)
            report_value("tm_dio_oe", dio_oe, !reading);
        b     = reading ? dio_in : dio_out;
        shift = {b, shift[7:1]};                       // LSB arrives first
        n_bits++;
        if (n_bits == 8)
        begin
            if (n_bytes < 17)
                cmd_bytes[n_bytes] = shift;
            n_bytes++;
            n_bits = 0;
        end
    endtask

    // Pins are sampled mid-cycle, away from the DUT's clock edge
    always @(negedge clk)
    begin
        if (reset)
        begin
            prev_sclk = 1'b1;
            prev_stb  = 1'b1;
        end
        else
        begin
            cycle++;
            if (prev_stb && !sio_stb)
            begin
                frame_started = 1'b1;
                n_bytes       = 0;
                n_bits        = 0;
            end
            if (!frame_started)
            begin
                if (sio_stb !== 1'b1)
                    report_value("tm_sio_stb", sio_stb, 1);
                if (sio_clk !== 1'b1)
                    report_value("tm_sio_clk", sio_clk, 1);
                if (dio_out !== 1'b1 || dio_oe !== 1'b1)
                    report_value("tm_dio_out and tm_dio_oe", {dio_out, dio_oe}, 2'b11);
                if (led !== '1)
                    report_value("LED", led, {w_led {1'b1}});
            end
            if (!prev_sclk && sio_clk && !sio_stb)
                take_bit();
            if (!prev_stb && sio_stb)
                end_command();
            prev_sclk = sio_clk;
            prev_stb  = sio_stb;
        end
    end

endmodule

`default_nettype wire

// File: src/board_specific_top.sv
`default_nettype none

module board_specific_top
#(
    parameter clk_mhz            = 100,
              slow_tick_hz       = 1,
              tm_half_bit_cycles = 10,
              w_key              = 3,   // The last key is the board reset
              w_sw               = 2,
              w_led              = 2
)
(
    input  wire                 CLK,
    input  wire [w_key - 1:0]   KEY,
    input  wire [w_sw  - 1:0]   SW,
    output wire [w_led - 1:0]   LED,
    output wire                 tm_sio_clk,
    output wire                 tm_sio_stb,
    output wire                 tm_dio_out,
    output wire                 tm_dio_oe,
    input  wire                 tm_dio_in
);

    import board_pkg::*;

    wire clk   = CLK;
    wire reset = ~ KEY[w_key - 1];     // Board buttons are active low

    wire                         tick;
    wire [w_tm_key   - 1:0]      tm_key;
    wire [w_tm_led   - 1:0]      tm_led;
    wire [w_led      - 1:0]      lab_led;
    wire [w_tm_digit - 1:0][7:0] abcdefgh;
    wire [w_tm_digit - 1:0][7:0] hgfedcba;

    slow_tick_gen #(.clk_mhz (clk_mhz), .slow_tick_hz (slow_tick_hz))
    i_slow_tick_gen (.clk (clk), .reset (reset), .tick (tick));

    lab_top
    #(
        .clk_mhz ( clk_mhz ),
        .w_sw    ( w_sw    ),
        .w_led   ( w_led   )
    )
    i_lab_top
    (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .tick     ( tick     ),
        .key      ( tm_key   ),
        .sw       ( SW       ),
        .led      ( lab_led  ),
        .abcdefgh ( abcdefgh ),
        .tm_led   ( tm_led   )
    );

    assign LED = ~ lab_led;            // On-board LEDs light when low

    // The panel wants segment a in bit 0
    for (genvar d = 0; d < w_tm_digit; d++)
    begin : g_digit
        for (genvar b = 0; b < 8; b++)
        begin : g_seg
            assign hgfedcba[d][b] = abcdefgh[d][7 - b];
        end
    end

    tm1638_board_controller
    #(
        .clk_mhz            ( clk_mhz            ),
        .tm_half_bit_cycles ( tm_half_bit_cycles )
    )
    i_tm1638
    (
        .clk      ( clk        ),
        .reset    ( reset      ),
        .hgfedcba ( hgfedcba   ),
        .tm_led   ( tm_led     ),
        .tm_key   ( tm_key     ),
        .sio_clk  ( tm_sio_clk ),
        .sio_stb  ( tm_sio_stb ),
        .dio_out  ( tm_dio_out ),
        .dio_oe   ( tm_dio_oe  ),
        .dio_in   ( tm_dio_in  )
    );

endmodule

`default_nettype wire

// File: src/tm1638_board_controller.sv
`default_nettype none

module tm1638_board_controller
#(
    parameter clk_mhz            = 100,
              tm_half_bit_cycles = 10
)
(
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire  [board_pkg::w_tm_digit - 1:0][7:0]    hgfedcba,
    input  wire  [board_pkg::w_tm_led   - 1:0]         tm_led,
    output logic [board_pkg::w_tm_key   - 1:0]         tm_key,
    output logic                                       sio_clk,
    output logic                                       sio_stb,
    output logic                                       dio_out,
    output logic                                       dio_oe,
    input  wire                                        dio_in
);

    import board_pkg::*;

    // A zero setting falls back to one microsecond per half bit
    localparam int half_cycles = tm_half_bit_cycles > 0 ? tm_half_bit_cycles : clk_mhz;
    localparam int w_phase     = half_cycles > 1 ? $clog2(half_cycles) : 1;

    // Byte positions inside one frame of 24 bytes
    localparam logic [4:0] byte_addr     = 5'd1;
    localparam logic [4:0] byte_last_led = 5'd17;
    localparam logic [4:0] byte_disp     = 5'd18;
    localparam logic [4:0] byte_read     = 5'd19;
    localparam logic [4:0] byte_first_in = 5'd20;
    localparam logic [4:0] byte_last     = 5'd23;

    typedef enum logic [1:0]
    {
        st_gap,    // Strobe high between commands
        st_start,  // Strobe low, clock still high
        st_low,
        st_high
    } state_t;

    state_t                       state;
    logic [w_phase - 1:0]         phase;
    logic                         half_end;
    logic                         gap_second;
    logic [2:0]                   bit_idx;
    logic [4:0]                   byte_idx;
    logic [4:0]                   load_idx;
    logic [3:0]                   slot;
    logic [7:0]                   load_byte;
    logic                         cmd_end;
    logic [7:0]                   tx;
    logic [31:0]                  rx;        // Four key bytes, first bit ends up in bit 0
    logic                         keys_done;
    logic [w_tm_key - 1:0]        key_map;
    logic [w_tm_digit - 1:0][7:0] digit_lat;
    logic [w_tm_led - 1:0]        led_lat;

    assign half_end = (phase == w_phase'(half_cycles - 1));

    always_ff @(posedge clk)
    begin
        if (reset || half_end)
            phase <= '0;
        else
            phase <= phase + 1'b1;
    end

    // The first byte of a command comes from byte_idx, later ones from the next slot
    assign load_idx = (state == st_start) ? byte_idx : byte_idx + 5'd1;
    assign slot     = 4'(load_idx - 5'd2);
    assign cmd_end  = (byte_idx == 5'd0) || (byte_idx == byte_last_led)
                   || (byte_idx == byte_disp) || (byte_idx == byte_last);

    always_comb
    begin
        case (load_idx)
            5'd0:      load_byte = tm_cmd_write_auto;
            byte_addr: load_byte = tm_cmd_addr0;
            byte_disp: load_byte = tm_cmd_display_on;
            byte_read: load_byte = tm_cmd_read_keys;
            default:
                if (load_idx > byte_last_led)
                    load_byte = 8'hFF;                      // Key bytes, line left high
                else if (slot[0])
                    load_byte = {7'd0, led_lat[slot[3:1]]};
                else
                    load_byte = digit_lat[slot[3:1]];
        endcase
    end

    // Even keys sit in bit 0 of a key byte, odd keys in bit 4
    for (genvar k = 0; k < w_tm_key; k++)
    begin : g_key_map
        assign key_map[k] = rx[(k / 2) * 8 + (k % 2) * 4];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= st_gap;
            gap_second <= 1'b0;
            bit_idx    <= '0;
            byte_idx   <= '0;
            keys_done  <= 1'b0;
            sio_clk    <= 1'b1;
            sio_stb    <= 1'b1;
            dio_out    <= 1'b1;
            dio_oe     <= 1'b1;
        end
        else
        begin
            keys_done <= 1'b0;

            if (half_end)
            begin
                case (state)
                    st_gap:
                    begin
                        gap_second <= ~ gap_second;

                        if (gap_second)
                        begin
                            state   <= st_start;
                            sio_stb <= 1'b0;
                        end
                    end
                    st_start:
                    begin
                        state   <= st_low;
                        sio_clk <= 1'b0;
                        bit_idx <= '0;
                        dio_out <= load_byte[0];
                        dio_oe  <= (load_idx < byte_first_in);
                    end
                    st_low:
                    begin
                        state     <= st_high;
                        sio_clk   <= 1'b1;   // Panel samples here, and so do we on key reads
                        keys_done <= (byte_idx == byte_last) && (bit_idx == 3'd7);
                    end
                    st_high:
                    begin
                        if (bit_idx != 3'd7)
                        begin
                            state   <= st_low;
                            sio_clk <= 1'b0;
                            bit_idx <= bit_idx + 3'd1;
                            dio_out <= tx[1];
                        end
                        else if (!cmd_end)
                        begin
                            state    <= st_low;
                            sio_clk  <= 1'b0;
                            bit_idx  <= '0;
                            byte_idx <= load_idx;
                            dio_out  <= load_byte[0];
                            dio_oe   <= (load_idx < byte_first_in);
                        end
                        else
                        begin
                            state    <= st_gap;
                            sio_stb  <= 1'b1;
                            dio_out  <= 1'b1;
                            dio_oe   <= 1'b1;
                            byte_idx <= (byte_idx == byte_last) ? 5'd0 : load_idx;
                        end
                    end
                    default:
                        state <= st_gap;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        // Snapshot the panel contents as the write command of a new frame begins
        if (half_end && state == st_gap && gap_second && byte_idx == 5'd0)
        begin
            digit_lat <= hgfedcba;
            led_lat   <= tm_led;
        end

        if (half_end && (state == st_start || (state == st_high && bit_idx == 3'd7)))
            tx <= load_byte;
        else if (half_end && state == st_high)
            tx <= tx >> 1;

        if (half_end && state == st_low && byte_idx >= byte_first_in)
            rx <= {dio_in, rx[31:1]};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            tm_key <= '0;
        else if (keys_done)
            tm_key <= key_map;
    end

endmodule

`default_nettype wire

// File: src/lab_top.sv
`default_nettype none

module lab_top
#(
    parameter clk_mhz = 100,
              w_sw    = 2,
              w_led   = 2
)
(
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire                                        tick,
    input  wire  [board_pkg::w_tm_key - 1:0]           key,
    input  wire  [w_sw - 1:0]                          sw,
    output wire  [w_led - 1:0]                         led,
    output wire  [board_pkg::w_tm_digit - 1:0][7:0]    abcdefgh,
    output wire  [board_pkg::w_tm_led - 1:0]           tm_led
);

    import board_pkg::*;

    // The lab needs both switches, a real clock and no more LEDs than count bits
    if (clk_mhz < 1 || w_sw < 2 || w_led > w_count)
    begin : g_bad_config
        $error("lab_top: unsupported clk_mhz, w_sw or w_led");
    end

    logic [w_tm_key - 1:0] key_r;     // Key state from the previous cycle
    logic [w_tm_key - 1:0] key_rise;
    logic [w_count  - 1:0] count;
    logic [w_count  - 1:0] step;

    assign key_rise = key & ~ key_r;

    // Events in the same cycle add up
    always_comb
    begin
        step = '0;

        if (key_rise[0])
            step = step + w_count'(1);

        if (key_rise[1])
            step = step + w_count'(16);

        if (tick && sw[0])
            step = step + w_count'(1);  // Slow ticks count only when enabled
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            key_r <= '0;
            count <= '0;
        end
        else
        begin
            key_r <= key;

            if (key_rise[w_tm_key - 1])
                count <= '0;            // The last key clears and wins over any add
            else
                count <= count + step;
        end
    end

    seven_seg_encoder i_seven_seg_encoder
    (
        .clk           ( clk      ),
        .reset         ( reset    ),
        .value         ( count    ),
        .blank_leading ( sw[1]    ),
        .abcdefgh      ( abcdefgh )
    );

    assign tm_led = key_r;
    assign led    = count[w_led - 1:0];

endmodule

`default_nettype wire

// File: src/seven_seg_encoder.sv
`default_nettype none

module seven_seg_encoder
(
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire  [board_pkg::w_count - 1:0]            value,
    input  wire                                        blank_leading,
    output logic [board_pkg::w_tm_digit - 1:0][7:0]    abcdefgh
);

    import board_pkg::*;

    logic [w_tm_digit - 1:0][7:0] seg_next;
    logic                         leading;  // Still inside the run of leading zeros

    // Walk from the most significant digit down, digit 0 always shows
    always_comb
    begin
        leading = blank_leading;

        for (int i = w_tm_digit - 1; i >= 0; i--)
        begin
            leading = leading && (i != 0) && (value[i * 4 +: 4] == 4'd0);

            if (leading)
                seg_next[i] = 8'h00;
            else
                seg_next[i] = seg_font[value[i * 4 +: 4]];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            abcdefgh <= '0;
        else
            abcdefgh <= seg_next;
    end

endmodule

`default_nettype wire

// File: src/slow_tick_gen.sv
`default_nettype none

module slow_tick_gen
#(
    parameter clk_mhz      = 100,
              slow_tick_hz = 1
)
(
    input  wire  clk,
    input  wire  reset,
    output logic tick
);

    // Number of clk cycles between two ticks
    localparam int unsigned divisor = clk_mhz * 1000000 / slow_tick_hz;
    localparam int          w_cnt   = divisor > 1 ? $clog2(divisor) : 1;

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cnt  <= w_cnt'(divisor - 1);
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            // Reload and pulse for exactly one cycle
            cnt  <= w_cnt'(divisor - 1);
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: src/board_pkg.sv
`default_nettype none

package board_pkg;

    // Front panel geometry
    localparam int w_tm_digit = 8;
    localparam int w_tm_led   = 8;
    localparam int w_tm_key   = 8;

    localparam logic [7:0] tm_cmd_write_auto = 8'h40;  // Data command, auto-increment write
    localparam logic [7:0] tm_cmd_read_keys  = 8'h42;  // Data command, key scan read
    localparam logic [7:0] tm_cmd_addr0      = 8'hC0;  // Address command, start at 0
    localparam logic [7:0] tm_cmd_display_on = 8'h8F;  // Display on, brightness 7 of 7

    localparam int w_count = 32;  // Eight hex digits

    // Segment patterns, bit 7 is segment a and bit 0 is the decimal point
    localparam logic [7:0] seg_font [16] = '{
        8'hFC,  // 0
        8'h60,  // 1
        8'hDA,  // 2
        8'hF2,  // 3
        8'h66,  // 4
        8'hB6,  // 5
        8'hBE,  // 6
        8'hE0,  // 7
        8'hFE,  // 8
        8'hF6,  // 9
        8'hEE,  // A
        8'h3E,  // b
        8'h9C,  // C
        8'h7A,  // d
        8'h9E,  // E
        8'h8E   // F
    };

endpackage

`default_nettype wire
